// ==== rtl/pcie_tlp_defs.svh ====
// --------------------
// Shared sizes and TLP header field positions for the TLP port emulation.
// Include this file wherever a width or a header field is needed.
// --------------------
`ifndef PCIE_TLP_DEFS_SVH
`define PCIE_TLP_DEFS_SVH

// Port count is at least 2 since there is no single-port bypass
`define PCIE_NUM_PORTS 4
`define PCIE_DATA_W    64
`define PCIE_PORT_W    2

// Header fields in beat 0 are packed down from the top bit
`define PCIE_OPCODE_HI 63
`define PCIE_OPCODE_LO 62
`define PCIE_PORT_HI   61
`define PCIE_PORT_LO   60
`define PCIE_TAG_HI    59
`define PCIE_TAG_LO    52
`define PCIE_LEN_HI    51
`define PCIE_LEN_LO    48
`define PCIE_ADDR_HI   31
`define PCIE_ADDR_LO   0

`endif

// ==== rtl/tlp_format_pkg.sv ====
// --------------------
// Opcode encoding and header field types of the TLP format.
// Helpers here read and build header beats.
// --------------------
`include "pcie_tlp_defs.svh"

package tlp_format_pkg;

    // Two-bit opcode carried in the top of the header beat
    typedef enum logic [1:0] {
        mem_rd = 2'd0,
        mem_wr = 2'd1,
        cpl    = 2'd2,
        cpl_d  = 2'd3
    } tlp_opcode_e;

    typedef logic [7:0] tlp_tag_t;
    typedef logic [3:0] tlp_len_t;

    // Opcode of a header beat
    function automatic tlp_opcode_e tlp_opcode(input logic [`PCIE_DATA_W-1:0] hdr);
        return tlp_opcode_e'(hdr[`PCIE_OPCODE_HI:`PCIE_OPCODE_LO]);
    endfunction

    // Tag of a header beat
    function automatic tlp_tag_t tlp_tag(input logic [`PCIE_DATA_W-1:0] hdr);
        return hdr[`PCIE_TAG_HI:`PCIE_TAG_LO];
    endfunction

    // Builds a header beat with zero in the bits outside the fields
    function automatic logic [`PCIE_DATA_W-1:0] tlp_make_hdr(
        input tlp_opcode_e           op,
        input logic [`PCIE_PORT_W-1:0] port,
        input tlp_tag_t              tag,
        input tlp_len_t              len,
        input logic [31:0]           addr
    );
        logic [`PCIE_DATA_W-1:0] hdr;
        hdr = '0;
        hdr[`PCIE_OPCODE_HI:`PCIE_OPCODE_LO] = op;
        hdr[`PCIE_PORT_HI:`PCIE_PORT_LO] = port;
        hdr[`PCIE_TAG_HI:`PCIE_TAG_LO] = tag;
        hdr[`PCIE_LEN_HI:`PCIE_LEN_LO] = len;
        hdr[`PCIE_ADDR_HI:`PCIE_ADDR_LO] = addr;
        return hdr;
    endfunction

endpackage

// ==== rtl/tlp_route_pkg.sv ====
// --------------------
// Port index and arbiter state encodings used for routing.
// --------------------
`include "pcie_tlp_defs.svh"

package tlp_route_pkg;

    typedef logic [`PCIE_PORT_W-1:0] port_idx_t;

    // Lane arbiter is either choosing or locked to one lane for a packet
    typedef enum logic [1:0] {
        idle = 2'd0,
        in_a = 2'd1,
        in_b = 2'd2
    } lane_arb_state_e;

    // Commit generator packet tracking
    typedef enum logic [1:0] {
        pass       = 2'd0,
        write_body = 2'd1,
        emit       = 2'd2
    } commit_state_e;

    // Destination port named in a header beat
    function automatic port_idx_t tlp_port(input logic [`PCIE_DATA_W-1:0] hdr);
        return hdr[`PCIE_PORT_HI:`PCIE_PORT_LO];
    endfunction

endpackage

// ==== rtl/tlp_port_mux.sv ====
// --------------------
// Function port multiplexer for one lane. Transmit packets from all ports are
// merged round-robin through an output register, and receive packets are
// steered to the port named in their header.
// --------------------
`timescale 1ns/1ps
`include "pcie_tlp_defs.svh"

module tlp_port_mux #(
    parameter int NUM_PORTS = `PCIE_NUM_PORTS
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [NUM_PORTS-1:0]    fn_tx_valid,
    output logic [NUM_PORTS-1:0]    fn_tx_ready,
    input  logic [NUM_PORTS-1:0]    fn_tx_last,
    input  logic [`PCIE_DATA_W-1:0] fn_tx_data [NUM_PORTS],

    output logic                    host_tx_valid,
    input  logic                    host_tx_ready,
    output logic                    host_tx_last,
    output logic [`PCIE_DATA_W-1:0] host_tx_data,

    input  logic                    host_rx_valid,
    output logic                    host_rx_ready,
    input  logic                    host_rx_last,
    input  logic [`PCIE_DATA_W-1:0] host_rx_data,

    output logic [NUM_PORTS-1:0]    fn_rx_valid,
    input  logic [NUM_PORTS-1:0]    fn_rx_ready,
    output logic [NUM_PORTS-1:0]    fn_rx_last,
    output logic [`PCIE_DATA_W-1:0] fn_rx_data [NUM_PORTS]
);

    import tlp_route_pkg::*;

    // Transmit arbitration state
    logic      tx_busy;
    port_idx_t tx_port;
    port_idx_t last_port;
    logic      rr_found;
    port_idx_t rr_pick;
    port_idx_t tx_grant;
    logic      tx_sel_valid;
    logic      tx_load;
    logic      tx_take;

    // Receive routing state
    logic                 rx_busy;
    port_idx_t            rx_port;
    port_idx_t            rx_route;
    logic [NUM_PORTS-1:0] rx_onehot;

    // Search for the next requesting port after the one served last
    // The served port itself is checked last so a lone requester still wins
    always_comb
    begin
        rr_found = 1'b0;
        rr_pick = last_port;
        for (int i = 1; i <= NUM_PORTS; i++)
        begin
            if (!rr_found && fn_tx_valid[(int'(last_port) + i) % NUM_PORTS])
            begin
                rr_found = 1'b1;
                rr_pick = port_idx_t'((int'(last_port) + i) % NUM_PORTS);
            end
        end
    end

    // Inside a packet the grant is locked to the port that started it
    assign tx_grant = tx_busy ? tx_port : rr_pick;
    assign tx_sel_valid = (tx_busy || rr_found) && fn_tx_valid[tx_grant];

    // The output register can take a beat when it is empty or draining
    assign tx_load = !host_tx_valid || host_tx_ready;
    assign tx_take = tx_sel_valid && tx_load;

    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            fn_tx_ready[i] = (tx_busy || rr_found) && (tx_grant == port_idx_t'(i)) && tx_load;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_busy <= 1'b0;
            tx_port <= '0;
            // Start so that port 0 is the first one served
            last_port <= port_idx_t'(NUM_PORTS - 1);
            host_tx_valid <= 1'b0;
        end
        else
        begin
            if (tx_load)
            begin
                host_tx_valid <= tx_sel_valid;
            end
            if (tx_take)
            begin
                tx_busy <= !fn_tx_last[tx_grant];
                tx_port <= tx_grant;
                if (fn_tx_last[tx_grant])
                begin
                    last_port <= tx_grant;
                end
            end
        end
    end

    // Payload of the output register
    always_ff @(posedge clk)
    begin
        if (tx_take)
        begin
            host_tx_last <= fn_tx_last[tx_grant];
            host_tx_data <= fn_tx_data[tx_grant];
        end
    end

    // Route comes from the header beat and is held until last
    assign rx_route = rx_busy ? rx_port : tlp_port(host_rx_data);

    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            rx_onehot[i] = (rx_route == port_idx_t'(i));
            fn_rx_last[i] = host_rx_last;
            fn_rx_data[i] = host_rx_data;
        end
    end

    assign fn_rx_valid = host_rx_valid ? rx_onehot : '0;

    // A packet naming a port that does not exist is consumed and dropped
    assign host_rx_ready = (|rx_onehot) ? |(rx_onehot & fn_rx_ready) : 1'b1;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_busy <= 1'b0;
            rx_port <= '0;
        end
        else if (host_rx_valid && host_rx_ready)
        begin
            rx_busy <= !host_rx_last;
            rx_port <= rx_route;
        end
    end

endmodule

// ==== rtl/tlp_lane_arbiter.sv ====
// --------------------
// Two-way packet arbiter that merges the A and B lane transmit streams.
// The data path is purely combinational and grants are held for whole packets.
// --------------------
`timescale 1ns/1ps
`include "pcie_tlp_defs.svh"

module tlp_lane_arbiter (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    a_valid,
    output logic                    a_ready,
    input  logic                    a_last,
    input  logic [`PCIE_DATA_W-1:0] a_data,

    input  logic                    b_valid,
    output logic                    b_ready,
    input  logic                    b_last,
    input  logic [`PCIE_DATA_W-1:0] b_data,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output logic [`PCIE_DATA_W-1:0] out_data
);

    import tlp_route_pkg::*;

    lane_arb_state_e state;

    // Set when the packet finished most recently came from lane B
    logic last_was_b;

    // Lane chosen this cycle
    logic use_b;

    always_comb
    begin
        case (state)
            in_a:    use_b = 1'b0;
            in_b:    use_b = 1'b1;
            default:
            begin
                // Both waiting means the lane not served last goes first
                if (a_valid && b_valid)
                begin
                    use_b = !last_was_b;
                end
                else
                begin
                    use_b = b_valid;
                end
            end
        endcase
    end

    assign out_valid = use_b ? b_valid : a_valid;
    assign out_last = use_b ? b_last : a_last;
    assign out_data = use_b ? b_data : a_data;

    assign a_ready = !use_b && out_ready;
    assign b_ready = use_b && out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= idle;
            last_was_b <= 1'b1;
        end
        else if (out_valid)
        begin
            if (out_ready && out_last)
            begin
                state <= idle;
                last_was_b <= use_b;
            end
            else
            begin
                // An offered beat keeps its lane until the last beat of its packet goes through
                state <= use_b ? in_b : in_a;
            end
        end
    end

endmodule

// ==== rtl/tlp_local_commit.sv ====
// --------------------
// Passes the merged transmit stream to the host and answers every memory
// write with a single-beat completion on the commit stream.
// --------------------
`timescale 1ns/1ps
`include "pcie_tlp_defs.svh"

module tlp_local_commit (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    arb_valid,
    output logic                    arb_ready,
    input  logic                    arb_last,
    input  logic [`PCIE_DATA_W-1:0] arb_data,

    output logic                    host_tx_valid,
    input  logic                    host_tx_ready,
    output logic                    host_tx_last,
    output logic [`PCIE_DATA_W-1:0] host_tx_data,

    output logic                    commit_valid,
    input  logic                    commit_ready,
    output logic                    commit_last,
    output logic [`PCIE_DATA_W-1:0] commit_data
);

    import tlp_format_pkg::*;
    import tlp_route_pkg::*;

    commit_state_e state;

    // High when the next beat on the stream is a header
    logic sop;

    // Source of the write being answered
    port_idx_t cmt_port;
    tlp_tag_t  cmt_tag;

    logic flow;
    logic xfer;
    logic is_wr_hdr;

    // Traffic stops while a commit waits so no new header slips by
    assign flow = (state != emit);

    assign host_tx_valid = arb_valid && flow;
    assign host_tx_last = arb_last;
    assign host_tx_data = arb_data;
    assign arb_ready = host_tx_ready && flow;

    assign xfer = host_tx_valid && host_tx_ready;
    assign is_wr_hdr = sop && (tlp_opcode(arb_data) == mem_wr);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= pass;
            sop <= 1'b1;
        end
        else
        begin
            if (xfer)
            begin
                sop <= arb_last;
            end
            case (state)
                pass:
                begin
                    if (xfer && is_wr_hdr)
                    begin
                        state <= arb_last ? emit : write_body;
                    end
                end
                write_body:
                begin
                    if (xfer && arb_last)
                    begin
                        state <= emit;
                    end
                end
                default:
                begin
                    if (commit_ready)
                    begin
                        state <= pass;
                    end
                end
            endcase
        end
    end

    // Port and tag are taken from every write header
    always_ff @(posedge clk)
    begin
        if (xfer && is_wr_hdr)
        begin
            cmt_port <= tlp_port(arb_data);
            cmt_tag <= tlp_tag(arb_data);
        end
    end

    // The commit is a plain completion header of length 1
    assign commit_valid = (state == emit);
    assign commit_last = 1'b1;
    assign commit_data = tlp_make_hdr(cpl, cmt_port, cmt_tag, tlp_len_t'(1), 32'h0);

endmodule

// ==== rtl/pcie_tlp_emul_top.sv ====
// --------------------
// Top of the TLP port emulation. Function ports on one side, a single host
// transmit and receive stream on the other, for a testbench to drive.
// --------------------
`timescale 1ns/1ps
`include "pcie_tlp_defs.svh"

module pcie_tlp_emul_top #(
    parameter int NUM_PORTS = `PCIE_NUM_PORTS
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [NUM_PORTS-1:0]    fn_tx_a_valid,
    output logic [NUM_PORTS-1:0]    fn_tx_a_ready,
    input  logic [NUM_PORTS-1:0]    fn_tx_a_last,
    input  logic [`PCIE_DATA_W-1:0] fn_tx_a_data [NUM_PORTS],

    input  logic [NUM_PORTS-1:0]    fn_tx_b_valid,
    output logic [NUM_PORTS-1:0]    fn_tx_b_ready,
    input  logic [NUM_PORTS-1:0]    fn_tx_b_last,
    input  logic [`PCIE_DATA_W-1:0] fn_tx_b_data [NUM_PORTS],

    output logic [NUM_PORTS-1:0]    fn_rx_a_valid,
    input  logic [NUM_PORTS-1:0]    fn_rx_a_ready,
    output logic [NUM_PORTS-1:0]    fn_rx_a_last,
    output logic [`PCIE_DATA_W-1:0] fn_rx_a_data [NUM_PORTS],

    output logic [NUM_PORTS-1:0]    fn_rx_b_valid,
    input  logic [NUM_PORTS-1:0]    fn_rx_b_ready,
    output logic [NUM_PORTS-1:0]    fn_rx_b_last,
    output logic [`PCIE_DATA_W-1:0] fn_rx_b_data [NUM_PORTS],

    output logic                    host_tx_valid,
    input  logic                    host_tx_ready,
    output logic                    host_tx_last,
    output logic [`PCIE_DATA_W-1:0] host_tx_data,

    input  logic                    host_rx_valid,
    output logic                    host_rx_ready,
    input  logic                    host_rx_last,
    input  logic [`PCIE_DATA_W-1:0] host_rx_data
);

    // Per-lane merged transmit streams
    logic                    mux_a_tx_valid;
    logic                    mux_a_tx_ready;
    logic                    mux_a_tx_last;
    logic [`PCIE_DATA_W-1:0] mux_a_tx_data;
    logic                    mux_b_tx_valid;
    logic                    mux_b_tx_ready;
    logic                    mux_b_tx_last;
    logic [`PCIE_DATA_W-1:0] mux_b_tx_data;

    // Lanes A and B merged, before commit generation
    logic                    arb_tx_valid;
    logic                    arb_tx_ready;
    logic                    arb_tx_last;
    logic [`PCIE_DATA_W-1:0] arb_tx_data;

    // Locally made write completions, delivered on receive lane B
    logic                    commit_rx_valid;
    logic                    commit_rx_ready;
    logic                    commit_rx_last;
    logic [`PCIE_DATA_W-1:0] commit_rx_data;

    // Lane A receives host traffic
    tlp_port_mux #(.NUM_PORTS(NUM_PORTS)) port_mux_a (
        .clk, .reset,
        .fn_tx_valid(fn_tx_a_valid), .fn_tx_ready(fn_tx_a_ready),
        .fn_tx_last(fn_tx_a_last), .fn_tx_data(fn_tx_a_data),
        .host_tx_valid(mux_a_tx_valid), .host_tx_ready(mux_a_tx_ready),
        .host_tx_last(mux_a_tx_last), .host_tx_data(mux_a_tx_data),
        .host_rx_valid, .host_rx_ready, .host_rx_last, .host_rx_data,
        .fn_rx_valid(fn_rx_a_valid), .fn_rx_ready(fn_rx_a_ready),
        .fn_rx_last(fn_rx_a_last), .fn_rx_data(fn_rx_a_data)
    );

    // Lane B receives only the commits
    tlp_port_mux #(.NUM_PORTS(NUM_PORTS)) port_mux_b (
        .clk, .reset,
        .fn_tx_valid(fn_tx_b_valid), .fn_tx_ready(fn_tx_b_ready),
        .fn_tx_last(fn_tx_b_last), .fn_tx_data(fn_tx_b_data),
        .host_tx_valid(mux_b_tx_valid), .host_tx_ready(mux_b_tx_ready),
        .host_tx_last(mux_b_tx_last), .host_tx_data(mux_b_tx_data),
        .host_rx_valid(commit_rx_valid), .host_rx_ready(commit_rx_ready),
        .host_rx_last(commit_rx_last), .host_rx_data(commit_rx_data),
        .fn_rx_valid(fn_rx_b_valid), .fn_rx_ready(fn_rx_b_ready),
        .fn_rx_last(fn_rx_b_last), .fn_rx_data(fn_rx_b_data)
    );

    tlp_lane_arbiter lane_arb (
        .clk, .reset,
        .a_valid(mux_a_tx_valid), .a_ready(mux_a_tx_ready),
        .a_last(mux_a_tx_last), .a_data(mux_a_tx_data),
        .b_valid(mux_b_tx_valid), .b_ready(mux_b_tx_ready),
        .b_last(mux_b_tx_last), .b_data(mux_b_tx_data),
        .out_valid(arb_tx_valid), .out_ready(arb_tx_ready),
        .out_last(arb_tx_last), .out_data(arb_tx_data)
    );

    // Writes are committed only after lane arbitration, so commit order
    // follows the order the host sees
    tlp_local_commit local_commit (
        .clk, .reset,
        .arb_valid(arb_tx_valid), .arb_ready(arb_tx_ready),
        .arb_last(arb_tx_last), .arb_data(arb_tx_data),
        .host_tx_valid, .host_tx_ready, .host_tx_last, .host_tx_data,
        .commit_valid(commit_rx_valid), .commit_ready(commit_rx_ready),
        .commit_last(commit_rx_last), .commit_data(commit_rx_data)
    );

endmodule

// ==== verification/tb_pcie_tlp_emul.sv ====
// --------------------
// Testbench for the TLP port emulation top. It sends random packets from every
// function source and from the host, and checks the results against queue models.
// --------------------
`timescale 1ns/1ps
`include "pcie_tlp_defs.svh"

module tb_pcie_tlp_emul;

    import tlp_format_pkg::*;

    localparam int N = `PCIE_NUM_PORTS;
    localparam int NUM_SRC = 2 * N;
    localparam int PKTS_PER_SRC = 12;
    localparam int HOST_PKTS = 32;
    localparam int PKT_COUNT = NUM_SRC * PKTS_PER_SRC + HOST_PKTS;
    // Up to 8 beats per packet, each waiting behind every port, with a margin of 4
    localparam int TIMEOUT_NS = PKT_COUNT * 8 * N * 40 * 4;

    // One beat as {last, data}
    typedef logic [`PCIE_DATA_W:0] beat_t;

    logic                    clk;
    logic                    reset;
    logic [N-1:0]            fn_tx_a_valid;
    logic [N-1:0]            fn_tx_a_ready;
    logic [N-1:0]            fn_tx_a_last;
    logic [`PCIE_DATA_W-1:0] fn_tx_a_data [N];
    logic [N-1:0]            fn_tx_b_valid;
    logic [N-1:0]            fn_tx_b_ready;
    logic [N-1:0]            fn_tx_b_last;
    logic [`PCIE_DATA_W-1:0] fn_tx_b_data [N];
    logic [N-1:0]            fn_rx_a_valid;
    logic [N-1:0]            fn_rx_a_ready;
    logic [N-1:0]            fn_rx_a_last;
    logic [`PCIE_DATA_W-1:0] fn_rx_a_data [N];
    logic [N-1:0]            fn_rx_b_valid;
    logic [N-1:0]            fn_rx_b_ready;
    logic [N-1:0]            fn_rx_b_last;
    logic [`PCIE_DATA_W-1:0] fn_rx_b_data [N];
    logic                    host_tx_valid;
    logic                    host_tx_ready;
    logic                    host_tx_last;
    logic [`PCIE_DATA_W-1:0] host_tx_data;
    logic                    host_rx_valid;
    logic                    host_rx_ready;
    logic                    host_rx_last;
    logic [`PCIE_DATA_W-1:0] host_rx_data;

    // Sources 0 to N-1 are lane A, N to 2N-1 are lane B
    // Beats still to be driven, and beats accepted but not yet seen on host_tx
    beat_t    drv_q [NUM_SRC][$];
    beat_t    exp_q [NUM_SRC][$];
    beat_t    hrx_q [$];
    beat_t    rx_exp_q [N][$];
    // Tags of the writes on host_tx that still wait for their commit
    tlp_tag_t cmt_q [N][$];
    // Packets from other sources on host_tx since this source was last served
    int       wait_cnt [NUM_SRC];

    // Handshakes seen at the negative edge, taking effect at the next rising edge
    logic [NUM_SRC-1:0]      src_fire;
    logic                    hrx_fire;
    // State of the packet in progress on host_tx
    logic                    tx_open;
    int                      tx_src;
    logic                    tx_is_wr;
    logic [`PCIE_PORT_W-1:0] tx_port;
    tlp_tag_t                tx_tag;

    // Every port name matches a signal of the same name here
    pcie_tlp_emul_top DUT (.*);

    always #20 clk = ~clk;

    task automatic value_mismatch(input string test, input beat_t expected, input beat_t actual);
        $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // Header beat from the field positions with every other bit zero
    function automatic logic [`PCIE_DATA_W-1:0] make_header(
        input tlp_opcode_e             op,
        input logic [`PCIE_PORT_W-1:0] port,
        input tlp_tag_t                tag,
        input logic [3:0]              len,
        input logic [31:0]             addr
    );
        logic [`PCIE_DATA_W-1:0] hdr;
        hdr = '0;
        hdr[`PCIE_OPCODE_HI:`PCIE_OPCODE_LO] = op;
        hdr[`PCIE_PORT_HI:`PCIE_PORT_LO] = port;
        hdr[`PCIE_TAG_HI:`PCIE_TAG_LO] = tag;
        hdr[`PCIE_LEN_HI:`PCIE_LEN_LO] = len;
        hdr[`PCIE_ADDR_HI:`PCIE_ADDR_LO] = addr;
        return hdr;
    endfunction

    task automatic build_stimulus();
        tlp_opcode_e             op;
        int                      len;
        int                      p;
        logic [`PCIE_DATA_W-1:0] hdr;
        beat_t                   beat;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            for (int k = 0; k < PKTS_PER_SRC; k++)
            begin
                op = ($urandom() % 2 != 0) ? mem_wr : mem_rd;
                len = int'($urandom_range(1, 8));
                // Tag bit 7 is the lane and the low bits count packets over all ports
                hdr = make_header(op, 2'(s % N),
                    8'((s / N) * 128 + (s % N) * PKTS_PER_SRC + k), 4'(len), $urandom());
                drv_q[s].push_back({len == 1, hdr});
                for (int b = 1; b < len; b++)
                begin
                    drv_q[s].push_back({b == len - 1, $urandom(), $urandom()});
                end
            end
        end
        // Host packets go to random ports and each port keeps its own arrival order
        for (int k = 0; k < HOST_PKTS; k++)
        begin
            p = int'($urandom() % N);
            op = ($urandom() % 2 != 0) ? cpl_d : cpl;
            len = int'($urandom_range(1, 8));
            hdr = make_header(op, 2'(p), 8'($urandom()), 4'(len), $urandom());
            for (int b = 0; b < len; b++)
            begin
                beat = (b == 0) ? {len == 1, hdr} : {b == len - 1, $urandom(), $urandom()};
                hrx_q.push_back(beat);
                rx_exp_q[p].push_back(beat);
            end
        end
    endtask

    // Applies the handshakes of the last edge and sets up the next beats
    task automatic drive_inputs();
        beat_t beat;
        int    p;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            if (src_fire[s])
            begin
                void'(drv_q[s].pop_front());
            end
            p = s % N;
            beat = (drv_q[s].size() > 0) ? drv_q[s][0] : '0;
            // Sources stay valid while they have data so that every port competes
            if (s < N)
            begin
                fn_tx_a_valid[p] = (drv_q[s].size() > 0);
                fn_tx_a_last[p] = beat[`PCIE_DATA_W];
                fn_tx_a_data[p] = beat[`PCIE_DATA_W-1:0];
            end
            else
            begin
                fn_tx_b_valid[p] = (drv_q[s].size() > 0);
                fn_tx_b_last[p] = beat[`PCIE_DATA_W];
                fn_tx_b_data[p] = beat[`PCIE_DATA_W-1:0];
            end
        end
        if (hrx_fire)
        begin
            void'(hrx_q.pop_front());
        end
        // The host may pause between beats but holds a raised valid
        if (!host_rx_valid || hrx_fire)
        begin
            host_rx_valid = (hrx_q.size() > 0) && ($urandom() % 4 != 0);
        end
        beat = (hrx_q.size() > 0) ? hrx_q[0] : '0;
        host_rx_last = beat[`PCIE_DATA_W];
        host_rx_data = beat[`PCIE_DATA_W-1:0];
        host_tx_ready = ($urandom() % 4 != 0);
        for (int i = 0; i < N; i++)
        begin
            fn_rx_a_ready[i] = ($urandom() % 4 != 0);
            fn_rx_b_ready[i] = ($urandom() % 3 != 0);
        end
        src_fire = '0;
        hrx_fire = 1'b0;
    endtask

    task automatic check_host_beat();
        beat_t exp_beat;
        beat_t act_beat;
        act_beat = {host_tx_last, host_tx_data};
        if (!tx_open)
        begin
            tx_src = int'(host_tx_data[`PCIE_TAG_HI]) * N
                + int'(host_tx_data[`PCIE_PORT_HI:`PCIE_PORT_LO]);
            tx_is_wr = (tlp_opcode_e'(host_tx_data[`PCIE_OPCODE_HI:`PCIE_OPCODE_LO]) == mem_wr);
            tx_port = host_tx_data[`PCIE_PORT_HI:`PCIE_PORT_LO];
            tx_tag = host_tx_data[`PCIE_TAG_HI:`PCIE_TAG_LO];
            // Every source still holding data has waited one more packet
            for (int s = 0; s < NUM_SRC; s++)
            begin
                if (s != tx_src && (drv_q[s].size() + exp_q[s].size()) > 0)
                begin
                    wait_cnt[s]++;
                    assert (wait_cnt[s] <= 2 * N)
                    else value_mismatch("fairness", beat_t'(2 * N), beat_t'(wait_cnt[s]));
                end
            end
            wait_cnt[tx_src] = 0;
        end
        assert (exp_q[tx_src].size() > 0)
        else abort_run("host_tx carried a beat that its source never sent");
        exp_beat = exp_q[tx_src].pop_front();
        assert (act_beat == exp_beat) else value_mismatch("transmit integrity", exp_beat, act_beat);
        tx_open = !host_tx_last;
        // A write is committed only once its last beat has reached the host
        if (host_tx_last && tx_is_wr)
        begin
            cmt_q[tx_port].push_back(tx_tag);
        end
    endtask

    // Called mid-cycle, when every valid and ready is steady until the next edge
    task automatic sample_handshakes();
        beat_t    exp_beat;
        beat_t    act_beat;
        tlp_tag_t tag;
        int       p;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            p = s % N;
            if (s < N)
            begin
                src_fire[s] = fn_tx_a_valid[p] && fn_tx_a_ready[p];
            end
            else
            begin
                src_fire[s] = fn_tx_b_valid[p] && fn_tx_b_ready[p];
            end
            if (src_fire[s])
            begin
                exp_q[s].push_back(drv_q[s][0]);
            end
        end
        hrx_fire = host_rx_valid && host_rx_ready;
        for (int i = 0; i < N; i++)
        begin
            if (fn_rx_a_valid[i] && fn_rx_a_ready[i])
            begin
                assert (rx_exp_q[i].size() > 0)
                else abort_run("fn_rx_a delivered more beats than the host sent to that port");
                exp_beat = rx_exp_q[i].pop_front();
                act_beat = {fn_rx_a_last[i], fn_rx_a_data[i]};
                assert (act_beat == exp_beat)
                else value_mismatch("receive routing", exp_beat, act_beat);
            end
            if (fn_rx_b_valid[i] && fn_rx_b_ready[i])
            begin
                assert (cmt_q[i].size() > 0)
                else abort_run("a commit arrived on fn_rx_b with no finished write before it");
                tag = cmt_q[i].pop_front();
                exp_beat = {1'b1, make_header(cpl, 2'(i), tag, 4'd1, 32'h0)};
                act_beat = {fn_rx_b_last[i], fn_rx_b_data[i]};
                assert (act_beat == exp_beat) else value_mismatch("commit", exp_beat, act_beat);
            end
        end
        // A write whose last beat reaches the host in this cycle is answered no earlier
        // than the next cycle
        if (host_tx_valid && host_tx_ready)
        begin
            check_host_beat();
        end
    endtask

    function automatic bit queues_empty();
        bit empty;
        empty = (hrx_q.size() == 0);
        for (int s = 0; s < NUM_SRC; s++)
        begin
            empty = empty && (drv_q[s].size() == 0) && (exp_q[s].size() == 0);
        end
        for (int i = 0; i < N; i++)
        begin
            empty = empty && (rx_exp_q[i].size() == 0) && (cmt_q[i].size() == 0);
        end
        return empty;
    endfunction

    task automatic check_idle_outputs();
        assert (host_tx_valid == 1'b0)
        else value_mismatch("reset host_tx_valid", '0, beat_t'(host_tx_valid));
        assert (fn_rx_a_valid == '0)
        else value_mismatch("reset fn_rx_a_valid", '0, beat_t'(fn_rx_a_valid));
        assert (fn_rx_b_valid == '0)
        else value_mismatch("reset fn_rx_b_valid", '0, beat_t'(fn_rx_b_valid));
    endtask

    // One clock drives after the edge, samples mid-cycle and waits for the next edge
    task automatic run_cycle();
        drive_inputs();
        @(negedge clk);
        sample_handshakes();
        @(posedge clk);
        #2;
    endtask

    initial
    begin : main_flow
        void'($urandom(32'h86fd));
        clk = 1'b0;
        reset = 1'b1;
        fn_tx_a_valid = '0;
        fn_tx_a_last = '0;
        fn_tx_b_valid = '0;
        fn_tx_b_last = '0;
        fn_rx_a_ready = '0;
        fn_rx_b_ready = '0;
        for (int i = 0; i < N; i++)
        begin
            fn_tx_a_data[i] = '0;
            fn_tx_b_data[i] = '0;
        end
        host_tx_ready = 1'b0;
        host_rx_valid = 1'b0;
        host_rx_last = 1'b0;
        host_rx_data = '0;
        src_fire = '0;
        hrx_fire = 1'b0;
        tx_open = 1'b0;
        tx_src = 0;
        tx_is_wr = 1'b0;
        tx_port = '0;
        tx_tag = '0;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            wait_cnt[s] = 0;
        end
        build_stimulus();
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_idle_outputs();
        end
        reset = 1'b0;
        // Inputs stay idle for the first cycle after reset
        @(posedge clk);
        #2;
        check_idle_outputs();
        while (!queues_empty())
        begin
            run_cycle();
        end
        // A few idle cycles catch any stray or duplicated beat
        repeat (8)
        begin
            run_cycle();
        end
        if (queues_empty())
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            abort_run("traffic was left undelivered at the end");
        end
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        abort_run("watchdog expired before all traffic was delivered and checked");
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/tlp_format_pkg.sv
rtl/tlp_route_pkg.sv
rtl/tlp_port_mux.sv
rtl/tlp_lane_arbiter.sv
rtl/tlp_local_commit.sv
rtl/pcie_tlp_emul_top.sv
verification/tb_pcie_tlp_emul.sv

// ==== Makefile ====
# Verilator build, run and lint of the TLP port emulation testbench

TOP := tb_pcie_tlp_emul

all: run

obj_dir/V$(TOP): tb.f rtl/*.sv rtl/*.svh verification/*.sv
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
